// ==== gf_pkg.sv ====
// Shared GF(2^8) field constants, types and table-building functions for the arithmetic pipeline.
`default_nettype none

package gf_pkg;

  // --------------------------------------------------
  // Field parameters
  // --------------------------------------------------

  localparam int GF_M       = 8;             // Bits per field element.
  localparam int GF_IRRPOL  = 285;           // x^8 + x^4 + x^3 + x^2 + 1, top bit included.
  localparam int GF_SIZE    = 2 ** GF_M;     // Number of field elements.
  localparam int GF_LATENCY = 3;             // Enabled edges from input sample to result.

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  typedef logic [GF_M-1:0] gf_data_t;        // One field element in polynomial basis.
  typedef gf_data_t gf_rom_t [GF_SIZE];      // One lookup table over all elements.

  // Operation select carried down the pipeline.
  typedef enum logic {
    GF_OP_MUL = 1'b0,                        // Result is a times d.
    GF_OP_DIV = 1'b1                         // Result is a divided by d.
  } gf_op_t;

  // --------------------------------------------------
  // Table builders, evaluated at elaboration
  // --------------------------------------------------

  // Power table. Entry i holds alpha^i for i in 0..GF_SIZE-2.
  // The last entry is 0 and pairs with the log of zero below.
  function automatic gf_rom_t gen_alpha_to();
    gf_rom_t           tbl;
    logic [GF_M:0]     acc;
    acc = (GF_M+1)'(1);
    for (int i = 0; i < GF_SIZE - 1; i++) begin
      tbl[i] = acc[GF_M-1:0];
      acc    = acc << 1;                      // Multiply by alpha.
      if (acc[GF_M]) begin
        acc = acc ^ (GF_M+1)'(GF_IRRPOL);     // Reduce by the generator.
      end
    end
    tbl[GF_SIZE-1] = '0;
    return tbl;
  endfunction

  // Log table, the inverse mapping of the power table.
  // Zero has no log, so it gets the out-of-range index GF_SIZE-1.
  function automatic gf_rom_t gen_index_of(input gf_rom_t alpha_to);
    gf_rom_t tbl;
    tbl[0] = gf_data_t'(GF_SIZE - 1);
    for (int i = 0; i < GF_SIZE - 1; i++) begin
      tbl[alpha_to[i]] = gf_data_t'(i);
    end
    return tbl;
  endfunction

  // Inverse table. For nonzero x, 1/x = alpha^((n - log x) mod n) with n = GF_SIZE-1.
  // Entry 0 is defined as 0 so a zero divisor gives a zero quotient.
  function automatic gf_rom_t gen_inv_table(input gf_rom_t alpha_to,
                                            input gf_rom_t index_of);
    gf_rom_t tbl;
    int      e;
    tbl[0] = '0;
    for (int x = 1; x < GF_SIZE; x++) begin
      e      = ((GF_SIZE - 1) - int'(index_of[x])) % (GF_SIZE - 1);
      tbl[x] = alpha_to[e];
    end
    return tbl;
  endfunction

  // --------------------------------------------------
  // Field multiply
  // --------------------------------------------------

  // Shift-and-reduce product. Each set bit of b adds the current multiple of a,
  // and a is stepped by alpha with reduction after every bit.
  function automatic gf_data_t gf_mult(input gf_data_t a, input gf_data_t b);
    gf_data_t      prod;
    logic [GF_M:0] sh;
    prod = '0;
    sh   = {1'b0, a};
    for (int i = 0; i < GF_M; i++) begin
      if (b[i]) begin
        prod = prod ^ sh[GF_M-1:0];
      end
      sh = sh << 1;
      if (sh[GF_M]) begin
        sh = sh ^ (GF_M+1)'(GF_IRRPOL);
      end
    end
    return prod;
  endfunction

endpackage

`default_nettype wire

// ==== gf_inv_rom.sv ====
// Registered inverse lookup over GF(2^8); the divider feeds it the divisor and reads 1/d a cycle later.
`default_nettype none

module gf_inv_rom (
  input  logic             iclk,
  input  logic             clkena,
  input  gf_pkg::gf_data_t addr,
  output gf_pkg::gf_data_t inv
);

  // --------------------------------------------------
  // Table contents
  // --------------------------------------------------

  // All three tables are constant functions of the generator polynomial,
  // so synthesis folds them into a single 256 x 8 ROM.
  gf_pkg::gf_rom_t alpha_to;   // Power table.
  gf_pkg::gf_rom_t index_of;   // Log table.
  gf_pkg::gf_rom_t inv_table;  // Multiplicative inverses. Entry 0 is 0.

  assign alpha_to  = gf_pkg::gen_alpha_to();
  assign index_of  = gf_pkg::gen_index_of(alpha_to);
  assign inv_table = gf_pkg::gen_inv_table(alpha_to, index_of);

  // --------------------------------------------------
  // Registered read
  // --------------------------------------------------

  // The output register sits in the same enabled stage as the divider's
  // first pipeline register.
  always_ff @(posedge iclk) begin
    if (clkena) begin
      inv <= inv_table[addr];   // Read advances only on enabled edges.
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // A zero address must read back zero one enabled edge later, which is
  // what makes a divide by zero come out as 0 at the end of the pipeline.
  // The next edge may be disabled, so the check waits for the read itself.
  a_zero_maps_to_zero : assert property (
    @(posedge iclk)
    (clkena && addr == '0) |=> (inv == '0)
  ) else $error("gf_inv_rom: inverse of 0 is not 0");

endmodule

`default_nettype wire

// ==== gf_div.sv ====
// Three-stage GF(2^8) multiply-or-divide pipeline with a shared multiplier and registered inverse ROM.
`default_nettype none

module gf_div (
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             clkena,
  input  logic             ena,
  input  gf_pkg::gf_op_t   op,
  input  gf_pkg::gf_data_t dat_a,
  input  gf_pkg::gf_data_t dat_d,
  output logic             val,
  output gf_pkg::gf_data_t odat,
  output logic             div_zero
);

  // --------------------------------------------------
  // Stage signals
  // --------------------------------------------------

  gf_pkg::gf_data_t rom_inv;    // 1/dat_d, aligned with stage 1.

  gf_pkg::gf_data_t s1_a;       // Dividend or first factor.
  gf_pkg::gf_data_t s1_d;       // Raw second operand.
  gf_pkg::gf_op_t   s1_op;
  logic             s1_val;
  logic             s1_zero;    // Divide with a zero divisor.

  gf_pkg::gf_data_t s2_a;
  gf_pkg::gf_data_t s2_b;       // Selected second factor.
  gf_pkg::gf_op_t   s2_op;
  logic             s2_val;
  logic             s2_zero;

  gf_pkg::gf_op_t   s3_op;      // Kept beside the result for checking.
  gf_pkg::gf_data_t factor_b;

  // The ROM address is the live divisor, so the inverse lands in step with stage 1.
  gf_inv_rom rom0 (
    .iclk   (iclk),
    .clkena (clkena),
    .addr   (dat_d),
    .inv    (rom_inv)
  );

  // A divide uses the inverse, a multiply bypasses the ROM. Both paths
  // then go through the same multiplier, so latency does not depend on op.
  assign factor_b = (s1_op == gf_pkg::GF_OP_DIV) ? rom_inv : s1_d;

  // --------------------------------------------------
  // Control pipeline
  // --------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      s1_val   <= 1'b0;
      s1_zero  <= 1'b0;
      s2_val   <= 1'b0;
      s2_zero  <= 1'b0;
      val      <= 1'b0;
      div_zero <= 1'b0;
    end else if (clkena) begin   // A low clkena freezes every stage at once.
      s1_val   <= ena;
      s1_zero  <= ena && (op == gf_pkg::GF_OP_DIV) && (dat_d == '0);
      s2_val   <= s1_val;
      s2_zero  <= s1_zero;
      val      <= s2_val;
      div_zero <= s2_zero;
    end
  end

  // --------------------------------------------------
  // Data pipeline
  // --------------------------------------------------

  always_ff @(posedge iclk) begin
    if (clkena) begin
      s1_a  <= dat_a;                            // Stage 1 captures the operands.
      s1_d  <= dat_d;
      s1_op <= op;
      s2_a  <= s1_a;                             // Stage 2 holds both factors.
      s2_b  <= factor_b;
      s2_op <= s1_op;
      odat  <= gf_pkg::gf_mult(s2_a, s2_b);      // Stage 3, the product.
      s3_op <= s2_op;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The zero flag belongs to a valid divide, and the ROM entry for 0 must
  // have forced the product to zero three stages later.
  a_zero_only_div : assert property (
    @(posedge iclk) disable iff (!rst_n)
    div_zero |-> (val && s3_op == gf_pkg::GF_OP_DIV && odat == '0)
  ) else $error("gf_div: div_zero without a divide or with nonzero result");

  // Outputs hold across any stall.
  a_stall_holds : assert property (
    @(posedge iclk) disable iff (!rst_n)
    (rst_n && !clkena) |=> ($stable(val) && $stable(odat))
  ) else $error("gf_div: output moved while clkena was low");

endmodule

`default_nettype wire

// ==== gf_arith_top.sv ====
// Top level of the GF(2^8) arithmetic unit; connect this to the system or to the testbench.
`default_nettype none

module gf_arith_top (
  // --------------------------------------------------
  // Clock, reset and stall
  // --------------------------------------------------
  input  logic             iclk,      // Pipeline clock.
  input  logic             rst_n,     // Synchronous reset, active low.
  input  logic             clkena,    // Low level freezes the whole pipeline.

  // --------------------------------------------------
  // Operation input
  // --------------------------------------------------
  input  logic             ena,       // One-cycle strobe, sampled with clkena high.
  input  gf_pkg::gf_op_t   op,        // Multiply or divide.
  input  gf_pkg::gf_data_t dat_a,     // First operand, the dividend for a divide.
  input  gf_pkg::gf_data_t dat_d,     // Second operand, the divisor for a divide.

  // --------------------------------------------------
  // Result output
  // --------------------------------------------------
  output logic             val,       // Result strobe, GF_LATENCY enabled edges after ena.
  output gf_pkg::gf_data_t odat,      // Product or quotient.
  output logic             div_zero   // Divide had a zero divisor, odat is then 0.
);

  // The arithmetic pipeline. Multiply and divide share one path,
  // so results leave in the same order the operations arrived.
  gf_div div0 (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .clkena   (clkena),
    .ena      (ena),
    .op       (op),
    .dat_a    (dat_a),
    .dat_d    (dat_d),
    .val      (val),
    .odat     (odat),
    .div_zero (div_zero)
  );

endmodule

`default_nettype wire

// ==== tb_gf_arith.sv ====
// Testbench for the GF(2^8) arithmetic unit; replays the vector file with random stalls.
`default_nettype none

module tb_gf_arith;
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // Parameters and signals
  // --------------------------------------------------

  localparam int NUM_VEC        = 37;                 // Operations in the vector file.
  localparam int WORDS_PER_VEC  = 5;                  // op, a, d, expected, zero flag.
  localparam int TIMEOUT_CYCLES = NUM_VEC * 8 + 200;  // Generous bound for stalls and gaps.

  logic             iclk;
  logic             rst_n;
  logic             clkena;
  logic             ena;
  gf_pkg::gf_op_t   op;
  gf_pkg::gf_data_t dat_a;
  gf_pkg::gf_data_t dat_d;
  logic             val;
  gf_pkg::gf_data_t odat;
  logic             div_zero;

  logic [7:0]       vec_mem [0:NUM_VEC*WORDS_PER_VEC-1];  // Raw words from the file.
  gf_pkg::gf_data_t exp_dat_q [$];   // Expected results in input order.
  logic             exp_zero_q [$];  // Expected zero flags, kept in step.

  int seed = 32'h438b;
  int n_recv = 0;      // Results seen at enabled edges.
  int data_errs = 0;
  int flag_errs = 0;
  int seq_errs = 0;    // Results with nothing in flight, or missing results.

  gf_arith_top dut0 (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .clkena   (clkena),
    .ena      (ena),
    .op       (op),
    .dat_a    (dat_a),
    .dat_d    (dat_d),
    .val      (val),
    .odat     (odat),
    .div_zero (div_zero)
  );

  initial iclk = 1'b0;
  always #4 iclk = ~iclk;  // 8 ns period.

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_data(input gf_pkg::gf_data_t got, input gf_pkg::gf_data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("error at %0t: odat is %02h, expected %02h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("error at %0t: div_zero is %b, expected %b", $time, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Result monitor
  // --------------------------------------------------

  // Outputs are read at the rising edge, before the DUT updates them.
  // A result counts only at an enabled edge, since a stall holds val high.
  always @(posedge iclk) begin
    if (rst_n && clkena && val) begin
      if (exp_dat_q.size() == 0) begin
        seq_errs++;  // Covers a stray val after reset as well.
        $display("unexpected result at %0t: val was high with no operation in flight", $time);
      end else begin
        check_data(odat, exp_dat_q.pop_front());
        check_flag(div_zero, exp_zero_q.pop_front());
        n_recv++;
      end
    end
  end

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge iclk);
      cycles++;
    end
    $display("timeout: results stopped arriving, %0d of %0d received", n_recv, NUM_VEC);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin : driver
    int idx;
    int base;
    rst_n  = 1'b0;
    clkena = 1'b0;
    ena    = 1'b0;
    op     = gf_pkg::GF_OP_MUL;
    dat_a  = '0;
    dat_d  = '0;
    idx    = 0;
    $readmemh("gf_arith_input.txt", vec_mem);

    repeat (16) @(posedge iclk);  // Reset held for 16 cycles.
    @(negedge iclk);
    rst_n = 1'b1;

    // A vector stays on the inputs until an edge with clkena high takes it.
    // Offers made while clkena is low must be ignored by the DUT.
    while (idx < NUM_VEC) begin
      @(negedge iclk);
      base   = idx * WORDS_PER_VEC;
      clkena = (($random(seed) & 3) != 0);   // Stalls about one cycle in four.
      ena    = (($random(seed) & 7) != 0);   // Occasional idle cycle.
      op     = gf_pkg::gf_op_t'(vec_mem[base][0]);
      dat_a  = vec_mem[base+1];
      dat_d  = vec_mem[base+2];
      if (ena && clkena) begin
        exp_dat_q.push_back(vec_mem[base+3]);
        exp_zero_q.push_back(vec_mem[base+4][0]);
        idx++;
      end
    end

    @(negedge iclk);
    ena = 1'b0;
    while (n_recv < NUM_VEC) begin  // Drain with stalls still running.
      @(negedge iclk);
      clkena = (($random(seed) & 3) != 0);
    end

    repeat (8) begin  // Any extra val now shows up in the monitor.
      @(negedge iclk);
      clkena = 1'b1;
    end
    @(negedge iclk);

    if (exp_dat_q.size() != 0) begin
      seq_errs++;
      $display("missing results: %0d operations never came out", exp_dat_q.size());
    end

    $display("errors: data %0d, zero flag %0d, sequence %0d", data_errs, flag_errs, seq_errs);
    if (data_errs + flag_errs + seq_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
gf_pkg.sv
gf_inv_rom.sv
gf_div.sv
gf_arith_top.sv
tb_gf_arith.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the GF(2^8) arithmetic testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_gf_arith \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// ==== gf_arith_input.txt ====
// Columns: op a d expected zero_flag, all hex, five words per operation.
// op 0 is a multiply (a times d), op 1 is a divide (a divided by d).
0 57 00 00 0
0 00 9a 00 0
1 01 02 8e 0
0 01 c3 c3 0
1 01 03 f4 0
0 b7 01 b7 0
0 8e 02 01 0
1 5a 00 00 1
1 01 04 47 0
0 02 80 1d 0
1 01 08 ad 0
0 1d 1d 4c 0
1 5a 5a 01 0
0 03 03 05 0
1 c9 c9 01 0
0 80 80 13 0
1 4c 1d 1d 0
0 74 3a 5a 0
1 06 03 02 0
0 e8 26 06 0
1 00 00 00 1
0 cd 13 06 0
1 4a 87 8f 0
0 03 f4 01 0
1 13 80 80 0
0 ff 02 e3 0
1 1e 05 06 0
0 10 10 1d 0
1 05 03 03 0
0 87 8f 4a 0
1 02 8e 04 0
0 05 06 1e 0
1 06 cd 13 0
1 ff 00 00 1
0 4c 2d 4e 0
1 00 37 00 0
1 e3 ff 02 0
